// ==== design/ram_array.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ram_settings.svh"

// Memory array shared by both ports
// Write on the clock edge, read combinationally at the registered read address
module ram_array (
    input  wire logic           a_outdata_aclr,

    // Registered write request from port A
    input  wire logic           wr_en_reg,
    input  wire ram_pkg::data_t wr_data_reg,
    input  wire ram_pkg::addr_t wr_address_reg,

    // Registered read address from port B
    input  wire ram_pkg::addr_t rd_address_reg,
    output ram_pkg::data_t      rd_word
);

    // Storage, contents are not cleared
    ram_pkg::data_t mem [`RAM_DEPTH];

    // Synchronous write of the registered request
    always_ff @(posedge a_outdata_aclr) begin
        if (wr_en_reg) begin
            mem[wr_address_reg] <= wr_data_reg;
        end
    end

    // Read side sees the word before any write on the same edge
    // so a same-address collision returns old data
    assign rd_word = mem[rd_address_reg];

    // A write that fires must carry a known address and data word
    property p_write_known;
        @(posedge a_outdata_aclr)
            wr_en_reg |-> !$isunknown({wr_address_reg, wr_data_reg});
    endproperty

    a_write_known : assert property (p_write_known)
        else $error("write to the array with unknown address or data");

endmodule : ram_array

`default_nettype wire

// ==== design/ram_pkg.sv ====
`default_nettype none

`include "ram_settings.svh"

// Shared vector types of the RAM
package ram_pkg;

    // One memory word, as written on port A and read on port B
    typedef logic [`RAM_DATA_WIDTH-1:0] data_t;

    // One word address
    typedef logic [`RAM_ADDR_WIDTH-1:0] addr_t;

    // All-zero values used by the register clears
    localparam data_t DATA_ZERO = '0;
    localparam addr_t ADDR_ZERO = '0;

endpackage : ram_pkg

`default_nettype wire

// ==== design/ram_read_port.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ram_settings.svh"

// Port B read registers
// Address register feeds the array and the output register captures its word
module ram_read_port (
    input  wire logic           a_outdata_aclr,
    input  wire logic           clock0,

    // Raw read request
    input  wire ram_pkg::addr_t rd_address,
    input  wire logic           rd_address_stall,
    input  wire logic           clocken_out,

    // Word returned by the array for rd_address_reg
    input  wire ram_pkg::data_t rd_word,

    output ram_pkg::addr_t      rd_address_reg,
    output ram_pkg::data_t      q
);

    // Read address register
    // While stalled it keeps pointing at the earlier word
    always_ff @(posedge a_outdata_aclr or posedge clock0) begin
        if (clock0) begin
            rd_address_reg <= ram_pkg::ADDR_ZERO;
        end else if (!rd_address_stall) begin
            rd_address_reg <= rd_address;
        end
    end

    // Output data register
    // Loads the addressed word one edge after the address was taken
    always_ff @(posedge a_outdata_aclr or posedge clock0) begin
        if (clock0) begin
            q <= ram_pkg::DATA_ZERO;
        end else if (clocken_out) begin
            q <= rd_word;
        end
    end

    // q must not move on the edge after clocken_out was low
    property p_q_hold;
        @(posedge a_outdata_aclr) disable iff (clock0)
            !clocken_out |=> $stable(q);
    endproperty

    a_q_hold : assert property (p_q_hold)
        else $error("q changed while clocken_out was low");

endmodule : ram_read_port

`default_nettype wire

// ==== design/ram_write_port.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ram_settings.svh"

// Port A input registers
// The write request is captured here and reaches the array one edge later
module ram_write_port (
    input  wire logic          a_outdata_aclr,
    input  wire logic          clock0,

    // Raw write request
    input  wire logic          wr_en,
    input  wire ram_pkg::data_t wr_data,
    input  wire ram_pkg::addr_t wr_address,
    input  wire logic          wr_address_stall,
    input  wire logic          clocken_in,

    // Registered write request towards the array
    output ram_pkg::data_t     wr_data_reg,
    output ram_pkg::addr_t     wr_address_reg,
    output logic               wr_en_reg
);

    // Write enable register
    // Cleared on reset so nothing is written while the RAM comes up
    always_ff @(posedge a_outdata_aclr or posedge clock0) begin
        if (clock0) begin
            wr_en_reg <= 1'b0;
        end else if (clocken_in) begin
            wr_en_reg <= wr_en;
        end
    end

    // Input data register
    always_ff @(posedge a_outdata_aclr or posedge clock0) begin
        if (clock0) begin
            wr_data_reg <= ram_pkg::DATA_ZERO;
        end else if (clocken_in) begin
            wr_data_reg <= wr_data;
        end
    end

    // Write address register
    // Only the stall holds it, the input clock enable has no say here
    always_ff @(posedge a_outdata_aclr or posedge clock0) begin
        if (clock0) begin
            wr_address_reg <= ram_pkg::ADDR_ZERO;
        end else if (!wr_address_stall) begin
            wr_address_reg <= wr_address;
        end
    end

    // Once out of reset the array must never see an unknown write enable
    property p_wr_en_known;
        @(posedge a_outdata_aclr) disable iff (clock0)
            !$isunknown(wr_en_reg);
    endproperty

    a_wr_en_known : assert property (p_wr_en_known)
        else $error("wr_en_reg is unknown after reset release");

endmodule : ram_write_port

`default_nettype wire

// ==== design/simple_dual_port_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ram_settings.svh"

// Simple dual-port RAM
// Port A writes, port B reads, one clock and one asynchronous clear
module simple_dual_port_ram (
    input  wire logic           a_outdata_aclr,
    input  wire logic           clock0,

    // Write port
    input  wire logic           wr_en,
    input  wire ram_pkg::data_t wr_data,
    input  wire ram_pkg::addr_t wr_address,
    input  wire logic           wr_address_stall,
    input  wire logic           clocken_in,

    // Read port
    input  wire ram_pkg::addr_t rd_address,
    input  wire logic           rd_address_stall,
    input  wire logic           clocken_out,
    output ram_pkg::data_t      q
);

    // Registered write request
    logic           wr_en_reg;
    ram_pkg::data_t wr_data_reg;
    ram_pkg::addr_t wr_address_reg;

    // Read side between array and read port
    ram_pkg::addr_t rd_address_reg;
    ram_pkg::data_t rd_word;

    ram_write_port u_write_port (
        .a_outdata_aclr   (a_outdata_aclr),
        .clock0           (clock0),
        .wr_en            (wr_en),
        .wr_data          (wr_data),
        .wr_address       (wr_address),
        .wr_address_stall (wr_address_stall),
        .clocken_in       (clocken_in),
        .wr_data_reg      (wr_data_reg),
        .wr_address_reg   (wr_address_reg),
        .wr_en_reg        (wr_en_reg)
    );

    ram_array u_array (
        .a_outdata_aclr (a_outdata_aclr),
        .wr_en_reg      (wr_en_reg),
        .wr_data_reg    (wr_data_reg),
        .wr_address_reg (wr_address_reg),
        .rd_address_reg (rd_address_reg),
        .rd_word        (rd_word)
    );

    // Output register loads rd_word, so q trails the address by two edges
    ram_read_port u_read_port (
        .a_outdata_aclr   (a_outdata_aclr),
        .clock0           (clock0),
        .rd_address       (rd_address),
        .rd_address_stall (rd_address_stall),
        .clocken_out      (clocken_out),
        .rd_word          (rd_word),
        .rd_address_reg   (rd_address_reg),
        .q                (q)
    );

endmodule : simple_dual_port_ram

`default_nettype wire

// ==== include/ram_settings.svh ====
`ifndef RAM_SETTINGS_SVH
`define RAM_SETTINGS_SVH

// Sizing of the simple dual-port RAM
// Every RTL file and the testbench take the widths from here

// Bits per memory word
`define RAM_DATA_WIDTH 16

// Address bits per word address
// Depth is always 2**RAM_ADDR_WIDTH words
`define RAM_ADDR_WIDTH 6

// Number of words in the array
`define RAM_DEPTH (1 << `RAM_ADDR_WIDTH)

`endif

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the RAM testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert \
        -f simple_dual_port_ram.f \
        --top-module tb_simple_dual_port_ram \
        -Mdir obj_dir; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vtb_simple_dual_port_ram)
status=$?
echo "$output"

if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "^=== PASS ===$"; then
    exit 0
fi
exit 1

// ==== simple_dual_port_ram.f ====
+incdir+include
design/ram_pkg.sv
design/ram_write_port.sv
design/ram_array.sv
design/ram_read_port.sv
design/simple_dual_port_ram.sv
tb/ram_checker.sv
tb/tb_simple_dual_port_ram.sv

// ==== tb/ram_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ram_settings.svh"

// Reference model of the RAM, compared against q on every falling edge
module ram_checker (
    input  wire logic           a_outdata_aclr,
    input  wire logic           clock0,
    input  wire logic           wr_en,
    input  wire ram_pkg::data_t wr_data,
    input  wire ram_pkg::addr_t wr_address,
    input  wire logic           wr_address_stall,
    input  wire logic           clocken_in,
    input  wire ram_pkg::addr_t rd_address,
    input  wire logic           rd_address_stall,
    input  wire logic           clocken_out,
    input  wire ram_pkg::data_t q,
    output int                  error_count,
    output int                  check_count
);

    ram_pkg::data_t mem [`RAM_DEPTH];
    logic           mem_valid [`RAM_DEPTH];

    // Model copies of the pipeline registers
    logic           m_wr_en;
    ram_pkg::data_t m_wr_data;
    ram_pkg::addr_t m_wr_addr;
    ram_pkg::addr_t m_rd_addr;
    ram_pkg::data_t m_q;
    logic           m_q_valid;

    int errors = 0;
    int checks = 0;

    assign error_count = errors;
    assign check_count = checks;

    // Nonblocking updates, so the q load sees the word before a same-edge write
    always @(posedge a_outdata_aclr) begin
        if (clock0) begin
            m_wr_en   <= 1'b0;
            m_wr_data <= '0;
            m_wr_addr <= '0;
            m_rd_addr <= '0;
            m_q       <= '0;
            m_q_valid <= 1'b1;
            for (int i = 0; i < `RAM_DEPTH; i++) begin
                mem_valid[i] <= 1'b0;
            end
        end else begin
            if (clocken_out) begin
                m_q       <= mem[m_rd_addr];
                m_q_valid <= mem_valid[m_rd_addr];
            end
            if (m_wr_en) begin
                mem[m_wr_addr]       <= m_wr_data;
                mem_valid[m_wr_addr] <= 1'b1;
            end
            if (clocken_in) begin
                m_wr_en   <= wr_en;
                m_wr_data <= wr_data;
            end
            if (!wr_address_stall) begin
                m_wr_addr <= wr_address;
            end
            if (!rd_address_stall) begin
                m_rd_addr <= rd_address;
            end
        end
    end

    // q is settled half a cycle after the edge
    always @(negedge a_outdata_aclr) begin
        if (!clock0 && m_q_valid) begin
            checks++;
            if (q !== m_q) begin
                errors++;
                $display("Fail at %0t: q expected %h, got %h", $time, m_q, q);
            end
        end
    end

endmodule : ram_checker

`default_nettype wire

// ==== tb/tb_simple_dual_port_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ram_settings.svh"

module tb_simple_dual_port_ram;

    localparam int RESET_CYCLES = 10;
    localparam int NUM_RANDOM   = 4000;
    localparam int WAIT_LIMIT   = 200;

    logic           a_outdata_aclr;
    logic           clock0;
    logic           wr_en;
    ram_pkg::data_t wr_data;
    ram_pkg::addr_t wr_address;
    logic           wr_address_stall;
    logic           clocken_in;
    ram_pkg::addr_t rd_address;
    logic           rd_address_stall;
    logic           clocken_out;
    ram_pkg::data_t q;

    integer seed;
    int     error_count;
    int     check_count;
    logic   timed_out;

    simple_dual_port_ram dut (
        .a_outdata_aclr   (a_outdata_aclr),
        .clock0           (clock0),
        .wr_en            (wr_en),
        .wr_data          (wr_data),
        .wr_address       (wr_address),
        .wr_address_stall (wr_address_stall),
        .clocken_in       (clocken_in),
        .rd_address       (rd_address),
        .rd_address_stall (rd_address_stall),
        .clocken_out      (clocken_out),
        .q                (q)
    );

    ram_checker chk (
        .a_outdata_aclr   (a_outdata_aclr),
        .clock0           (clock0),
        .wr_en            (wr_en),
        .wr_data          (wr_data),
        .wr_address       (wr_address),
        .wr_address_stall (wr_address_stall),
        .clocken_in       (clocken_in),
        .rd_address       (rd_address),
        .rd_address_stall (rd_address_stall),
        .clocken_out      (clocken_out),
        .q                (q),
        .error_count      (error_count),
        .check_count      (check_count)
    );

    initial begin
        a_outdata_aclr = 1'b0;
        forever #2 a_outdata_aclr = ~a_outdata_aclr;
    end

    // One cycle of inputs applied shortly after the rising edge
    task automatic apply_cycle(input logic we, input ram_pkg::data_t wd,
                               input ram_pkg::addr_t wa, input logic was,
                               input logic ci, input ram_pkg::addr_t ra,
                               input logic ras, input logic co);
        @(posedge a_outdata_aclr);
        #1;
        wr_en            = we;
        wr_data          = wd;
        wr_address       = wa;
        wr_address_stall = was;
        clocken_in       = ci;
        rd_address       = ra;
        rd_address_stall = ras;
        clocken_out      = co;
    endtask

    // Mixed traffic with half of it squeezed onto 8 addresses to force collisions
    task automatic random_cycle();
        logic [31:0]    r;
        ram_pkg::addr_t wa;
        ram_pkg::addr_t ra;
        r  = $random(seed);
        wa = ram_pkg::addr_t'(r >> 8);
        ra = ram_pkg::addr_t'(r >> 16);
        if (r[7]) begin
            wa = wa & ram_pkg::addr_t'(7);
            ra = ra & ram_pkg::addr_t'(7);
        end
        apply_cycle(r[0], ram_pkg::data_t'($random(seed)), wa, r[3:1] == 3'd0,
                    r[6:4] != 3'd0, ra, r[26:24] == 3'd0, r[29:27] != 3'd0);
    endtask

    // Wait until the checker has made at least one more comparison
    task automatic wait_for_check();
        int start;
        int n;
        start = check_count;
        n = 0;
        while (check_count <= start && n < WAIT_LIMIT) begin
            @(posedge a_outdata_aclr);
            n++;
        end
        if (check_count <= start) begin
            $display("Timeout: the checker made no new comparison within %0d cycles",
                     WAIT_LIMIT);
            timed_out = 1'b1;
        end
    endtask

    initial begin
        seed             = 32'h11d1cec3;
        timed_out        = 1'b0;
        clock0           = 1'b1;
        wr_en            = 1'b0;
        wr_data          = '0;
        wr_address       = '0;
        wr_address_stall = 1'b0;
        clocken_in       = 1'b0;
        rd_address       = '0;
        rd_address_stall = 1'b0;
        clocken_out      = 1'b0;
        repeat (RESET_CYCLES) @(posedge a_outdata_aclr);
        #1 clock0 = 1'b0;

        // q must stay at zero while the output register is not enabled
        repeat (4) apply_cycle(1'b0, '0, '0, 1'b0, 1'b1, '0, 1'b0, 1'b0);
        // Fill the lower words, then read them back
        for (int i = 0; i < 16; i++) begin
            apply_cycle(1'b1, ram_pkg::data_t'(32'h9e37 * (i + 1)), ram_pkg::addr_t'(i),
                        1'b0, 1'b1, '0, 1'b0, 1'b0);
        end
        for (int i = 0; i < 16; i++) begin
            apply_cycle(1'b0, '0, '0, 1'b0, 1'b1, ram_pkg::addr_t'(i), 1'b0, 1'b1);
        end
        // Input and output clock enables low
        apply_cycle(1'b1, ram_pkg::data_t'(16'h1234), 6'd5, 1'b0, 1'b0, 6'd2, 1'b0, 1'b0);
        apply_cycle(1'b0, '0, 6'd5, 1'b0, 1'b1, 6'd5, 1'b0, 1'b0);
        // Stalls hold the old addresses
        apply_cycle(1'b1, ram_pkg::data_t'(16'hbeef), 6'd7, 1'b0, 1'b1, 6'd7, 1'b0, 1'b1);
        apply_cycle(1'b1, ram_pkg::data_t'(16'hcafe), 6'd9, 1'b1, 1'b1, 6'd9, 1'b1, 1'b1);
        // Same-address read and write on one edge
        apply_cycle(1'b1, ram_pkg::data_t'(16'h5a5a), 6'd3, 1'b0, 1'b1, 6'd3, 1'b0, 1'b1);
        // Read back the word that the stalled write put at address 7
        apply_cycle(1'b0, '0, '0, 1'b0, 1'b1, 6'd7, 1'b0, 1'b1);
        apply_cycle(1'b0, '0, '0, 1'b0, 1'b1, 6'd3, 1'b0, 1'b1);

        repeat (NUM_RANDOM) random_cycle();
        apply_cycle(1'b0, '0, '0, 1'b0, 1'b1, 6'd3, 1'b0, 1'b1);
        wait_for_check();

        $display("Summary: %0d errors in %0d checks", error_count, check_count);
        if (error_count == 0 && !timed_out) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule : tb_simple_dual_port_ram

`default_nettype wire
